//--- files.f
hdl/riscv_pkg.sv
hdl/pc_sequencer.sv
hdl/fetcher.sv
hdl/instr_mem.sv
hdl/fetch_top.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_tb -f files.f -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import riscv_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int IDLE_CYCLES   = 10;
    localparam int SEQ_FETCHES   = 64;
    localparam int STALL_FETCHES = 64;
    localparam int REDIRECTS     = 12;
    localparam int MAX_GAP       = 8;     // Cycles between redirects.
    localparam int MAX_BURST     = 5;     // Longest stall burst.
    localparam int WRAP_FETCHES  = 3;
    localparam int DRAIN_CYCLES  = 12;
    localparam int MARGIN        = 100;
    localparam int TOTAL_FETCHES = 1 + SEQ_FETCHES + STALL_FETCHES + 2 + WRAP_FETCHES + 1;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + MEM_DEPTH + IDLE_CYCLES
                                 + TOTAL_FETCHES * (MEM_LATENCY + 2)
                                 + STALL_FETCHES * MAX_BURST
                                 + REDIRECTS * (MAX_GAP + 1)
                                 + 2 * DRAIN_CYCLES + MARGIN;
    localparam addr_t WRAP_PC    = 32'h0000_1a3c;   // Lands on index 8'h8f.

    logic     CLK;
    logic     RSTn;
    logic     run;
    logic     redirect;
    addr_t    redirect_pc;
    logic     mem_stall;
    logic     load_en;
    mem_idx_t load_addr;
    word_t    load_data;
    word_t    instr;
    addr_t    instr_pc;
    logic     instr_valid;
    logic     fetch_busy;

    word_t       shadow_mem [MEM_DEPTH];
    logic [31:0] rng_state = 32'hbc0466ec;

    // Model state owned by the comparing process.
    addr_t exp_pc     = RESET_PC;
    addr_t pend_pc    = RESET_PC;
    logic  pend_valid = 1'b0;
    addr_t last_pc    = '0;
    logic  wrap_seen  = 1'b0;
    int    fetch_cnt  = 0;
    int    cmp_errors = 0;
    int    cmp_checks = 0;

    int   tb_errors    = 0;
    int   tb_checks    = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    int   cycle_cnt    = 0;
    logic stall_done;

    fetch_top UUT (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_stall   (mem_stall),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .fetch_busy  (fetch_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = lcg_step(rng_state);
        v = rng_state;
    endtask

    // Word address modulo the memory depth.
    function automatic word_t expected_word(input addr_t a);
        return shadow_mem[mem_idx_t'(a >> 2)];
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic wait_fetches(input int n);
        int target;
        target = fetch_cnt + n;
        while (fetch_cnt < target) begin
            next_cycle();
        end
    endtask

    task automatic finish_test(input int num, input string name, input int err_start);
        int err_now;
        err_now = cmp_errors + tb_errors;
        tests_run++;
        if (err_now != err_start) begin
            tests_failed++;
            $display("Test %0d (%s): FAILED with %0d errors", num, name, err_now - err_start);
        end else begin
            $display("Test %0d (%s): ok", num, name);
        end
    endtask

    // Compare on the falling edge, where DUT outputs are settled.
    always @(negedge CLK) begin
        if (RSTn) begin
            if (instr_valid) begin
                cmp_checks = cmp_checks + 2;
                assert (instr_pc == exp_pc) else begin
                    cmp_errors++;
                    $display("[ERROR] %0t: instr_pc %h, expected %h", $time, instr_pc, exp_pc);
                end
                assert (instr == expected_word(exp_pc)) else begin
                    cmp_errors++;
                    $display("[ERROR] %0t: instr %h at pc %h, expected %h",
                             $time, instr, exp_pc, expected_word(exp_pc));
                end
                if (instr_pc == WRAP_PC) begin
                    wrap_seen = 1'b1;
                end
                last_pc = instr_pc;
                fetch_cnt++;
                exp_pc = pend_valid ? pend_pc : exp_pc + 32'd4;
                pend_valid = 1'b0;
            end
            // Seen from here on, a redirect steers the fetch after the current one.
            if (redirect) begin
                pend_valid = 1'b1;
                pend_pc    = redirect_pc;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: run hung after %0d cycles with %0d fetches seen",
                     cycle_cnt, fetch_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        int          err0;
        int          cnt0;
        int          gap;
        RSTn        = 1'b0;
        run         = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        mem_stall   = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        stall_done  = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RSTn = 1'b1;

        // Preload memory and shadow copy.
        for (int i = 0; i < MEM_DEPTH; i++) begin
            draw(r);
            shadow_mem[i] = r ^ (word_t'(i) << 24);
            load_en   = 1'b1;
            load_addr = mem_idx_t'(i);
            load_data = shadow_mem[i];
            next_cycle();
        end
        load_en = 1'b0;

        err0 = cmp_errors + tb_errors;
        repeat (IDLE_CYCLES) begin
            next_cycle();
            tb_checks++;
            assert (!instr_valid && !fetch_busy) else begin
                tb_errors++;
                $display("[ERROR] %0t: fetch activity while run is low", $time);
            end
        end
        run = 1'b1;
        wait_fetches(1);
        tb_checks++;
        assert (last_pc == RESET_PC) else begin
            tb_errors++;
            $display("[ERROR] %0t: first fetch at %h, expected %h", $time, last_pc, RESET_PC);
        end
        finish_test(1, "reset and first fetch", err0);

        err0 = cmp_errors + tb_errors;
        wait_fetches(SEQ_FETCHES);
        finish_test(2, "sequential fetch", err0);

        err0 = cmp_errors + tb_errors;
        fork
            begin
                while (!stall_done) begin
                    draw(r);
                    mem_stall = 1'b1;
                    repeat (1 + r[2:0] % MAX_BURST) next_cycle();
                    mem_stall = 1'b0;
                    repeat (1 + r[10:8] % MAX_BURST) next_cycle();
                end
            end
            begin
                wait_fetches(STALL_FETCHES);
                stall_done = 1'b1;
            end
        join
        finish_test(3, "random stall", err0);

        err0 = cmp_errors + tb_errors;
        for (int n = 0; n < REDIRECTS; n++) begin
            draw(r);
            gap = 1 + int'(r[3:0]) % MAX_GAP;
            repeat (gap) next_cycle();
            redirect    = 1'b1;
            redirect_pc = {22'd0, r[23:16], 2'b00};
            next_cycle();
            redirect = 1'b0;
        end
        wait_fetches(2);
        finish_test(4, "random redirect", err0);

        err0 = cmp_errors + tb_errors;
        redirect    = 1'b1;
        redirect_pc = WRAP_PC;
        next_cycle();
        redirect = 1'b0;
        wait_fetches(WRAP_FETCHES);
        tb_checks++;
        assert (wrap_seen) else begin
            tb_errors++;
            $display("No fetch was seen at the wrap target %h", WRAP_PC);
        end
        finish_test(5, "address wrap", err0);

        err0 = cmp_errors + tb_errors;
        next_cycle();
        next_cycle();
        cnt0 = fetch_cnt;
        run  = 1'b0;
        repeat (DRAIN_CYCLES) next_cycle();
        tb_checks++;
        assert (fetch_cnt - cnt0 <= 1) else begin
            tb_errors++;
            $display("Saw %0d fetches after run fell, at most one allowed", fetch_cnt - cnt0);
        end
        repeat (DRAIN_CYCLES) begin
            next_cycle();
            tb_checks++;
            assert (!fetch_busy && !instr_valid) else begin
                tb_errors++;
                $display("[ERROR] %0t: fetch still active after run fell", $time);
            end
        end
        finish_test(6, "run falls", err0);

        $display("Totals: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, cmp_checks + tb_checks, cmp_errors + tb_errors);
        if (cmp_errors + tb_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  logic                 run,
    input  logic                 redirect,
    input  riscv_pkg::addr_t     redirect_pc,
    input  logic                 mem_stall,
    input  logic                 load_en,
    input  riscv_pkg::mem_idx_t  load_addr,
    input  riscv_pkg::word_t     load_data,
    output riscv_pkg::word_t     instr,
    output riscv_pkg::addr_t     instr_pc,
    output logic                 instr_valid,
    output logic                 fetch_busy
);

    import riscv_pkg::*;

    logic  instr_req;
    addr_t pc;

    // Memory bus.
    req_e  mem_req;
    addr_t mem_addr;
    we_e   mem_we;
    word_t mem_wdata;
    logic  mem_rdy;
    logic  mem_valid;
    word_t mem_rdata;

    pc_sequencer u_seq (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .busy        (fetch_busy),
        .mem_valid   (mem_valid),
        .instr_req   (instr_req),
        .pc          (pc),
        .instr_pc    (instr_pc)
    );

    fetcher u_fetch (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .instr_req   (instr_req),
        .busy        (fetch_busy),
        .pc          (pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_rdy     (mem_rdy),
        .mem_valid   (mem_valid),
        .mem_rdata   (mem_rdata)
    );

    instr_mem u_mem (
        .CLK         (CLK),
        .RSTn        (RSTn),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_rdy     (mem_rdy),
        .mem_valid   (mem_valid),
        .mem_rdata   (mem_rdata),
        .mem_stall   (mem_stall),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

endmodule

//--- hdl/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  riscv_pkg::req_e      mem_req,
    input  riscv_pkg::addr_t     mem_addr,
    input  riscv_pkg::we_e       mem_we,
    input  riscv_pkg::word_t     mem_wdata,
    output logic                 mem_rdy,
    output logic                 mem_valid,
    output riscv_pkg::word_t     mem_rdata,
    input  logic                 mem_stall,
    input  logic                 load_en,
    input  riscv_pkg::mem_idx_t  load_addr,
    input  riscv_pkg::word_t     load_data
);

    import riscv_pkg::*;

    word_t    mem [MEM_DEPTH];
    lat_cnt_t lat_cnt;     // Cycles left until the response.
    mem_idx_t req_idx;
    word_t    rdata_q;
    logic     accept;

    // One word per index with the upper address bits wrapping.
    assign req_idx = mem_addr[MEM_ADDR_BITS+1:2];

    // Ready only with nothing outstanding and no stall.
    assign mem_rdy = (lat_cnt == '0) && !mem_stall;
    assign accept  = (mem_req == REQUEST) && mem_rdy;

    assign mem_valid = (lat_cnt == lat_cnt_t'(1));
    assign mem_rdata = rdata_q;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            lat_cnt <= '0;
        end else if (accept) begin
            lat_cnt <= lat_cnt_t'(MEM_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - lat_cnt_t'(1);
        end
    end

    // Load port has priority over a bus write.
    always_ff @(posedge CLK) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (accept && (mem_we == WRITE)) begin
            mem[req_idx] <= mem_wdata;
        end
    end

    // Word is captured on accept and held until the response.
    always_ff @(posedge CLK) begin
        if (accept && (mem_we == READ)) begin
            rdata_q <= mem[req_idx];
        end
    end

    // Preload must be finished before fetching starts.
    no_load_on_req_a : assert property (
        @(posedge CLK) disable iff (!RSTn)
        $rose(mem_req == REQUEST) |-> !load_en
    ) else $error("instr_mem: request raised during preload");

endmodule

//--- hdl/fetcher.sv
`timescale 1ns/1ps

module fetcher (
    input  logic               CLK,
    input  logic               RSTn,
    input  logic               instr_req,
    output logic               busy,
    input  riscv_pkg::addr_t   pc,
    output riscv_pkg::word_t   instr,
    output logic               instr_valid,
    output riscv_pkg::req_e    mem_req,
    output riscv_pkg::addr_t   mem_addr,
    output riscv_pkg::we_e     mem_we,
    output riscv_pkg::word_t   mem_wdata,
    input  logic               mem_rdy,
    input  logic               mem_valid,
    input  riscv_pkg::word_t   mem_rdata
);

    import riscv_pkg::*;

    fetch_state_e state;
    fetch_state_e next_state;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state <= WAIT_REQ;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;   // Hold unless a transition fires.
        case (state)
            WAIT_REQ: begin
                if (instr_req) begin
                    if (mem_rdy) begin
                        next_state = WAIT_VALID;
                    end else begin
                        next_state = WAIT_READY;
                    end
                end
            end
            WAIT_READY: begin
                if (mem_rdy) begin
                    next_state = WAIT_VALID;
                end
            end
            WAIT_VALID: begin
                if (mem_valid) begin
                    next_state = WAIT_REQ;
                end
            end
            default: begin
                next_state = WAIT_REQ;
            end
        endcase
    end

    // Request and busy levels per state.
    always_comb begin
        mem_req = NOREQUEST;
        busy    = 1'b0;
        case (state)
            WAIT_REQ: begin
                if (instr_req) begin
                    mem_req = REQUEST;
                    busy    = 1'b1;
                end
            end
            WAIT_READY: begin
                mem_req = REQUEST;   // Held through the stall.
                busy    = 1'b1;
            end
            WAIT_VALID: begin
                busy = !mem_valid;
            end
            default: begin
                mem_req = NOREQUEST;
                busy    = 1'b0;
            end
        endcase
    end

    // Fetch only reads.
    assign mem_addr  = pc;
    assign mem_we    = READ;
    assign mem_wdata = '0;

    always_ff @(posedge CLK) begin
        if (mem_valid) begin
            instr <= mem_rdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= mem_valid;   // One-cycle pulse.
        end
    end

    // Memory answers only to a request this FSM made.
    no_valid_when_idle_a : assert property (
        @(posedge CLK) disable iff (!RSTn)
        mem_valid |-> (state != WAIT_REQ)
    ) else $error("fetcher: mem_valid without outstanding request");

endmodule

//--- hdl/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
    input  logic             CLK,
    input  logic             RSTn,
    input  logic             run,
    input  logic             redirect,
    input  riscv_pkg::addr_t redirect_pc,
    input  logic             busy,
    input  logic             mem_valid,
    output logic             instr_req,
    output riscv_pkg::addr_t pc,
    output riscv_pkg::addr_t instr_pc
);

    import riscv_pkg::*;

    logic  issued;        // Request for the current PC already sent.
    logic  redir_pend;
    addr_t redir_target;
    addr_t next_pc;

    // One request per PC; the fetcher holds it from here on.
    assign instr_req = run && !issued;

    // A redirect in the completing cycle still counts for this update.
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (redir_pend) begin
            next_pc = redir_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            pc <= RESET_PC;
        end else if (mem_valid) begin
            pc <= next_pc;
        end
    end

    // PC of the completed fetch travels with the instruction.
    always_ff @(posedge CLK) begin
        if (mem_valid) begin
            instr_pc <= pc;
        end
    end

    // Redirect seen during a fetch waits for that fetch to complete.
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            redir_pend <= 1'b0;
        end else if (mem_valid) begin
            redir_pend <= 1'b0;
        end else if (redirect) begin
            redir_pend <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (redirect) begin
            redir_target <= redirect_pc;   // Latest target wins.
        end
    end

    // Next request opens one cycle after the update, once the fetcher is idle.
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            issued <= 1'b0;
        end else if (instr_req) begin
            issued <= 1'b1;
        end else if (!busy && !mem_valid) begin
            issued <= 1'b0;   // First idle cycle after the valid cycle.
        end
    end

    // Misaligned PCs are not supported.
    pc_aligned_a : assert property (
        @(posedge CLK) disable iff (!RSTn)
        pc[1:0] == 2'b00
    ) else $error("pc_sequencer: misaligned PC %h", pc);

endmodule

//--- hdl/riscv_pkg.sv
package riscv_pkg;

    // Memory geometry and timing.
    localparam int MEM_ADDR_BITS = 8;
    localparam int MEM_DEPTH     = 1 << MEM_ADDR_BITS;   // 256 words.
    localparam int MEM_LATENCY   = 2;                    // Accept to valid, in cycles.
    localparam int LAT_CNT_BITS  = $clog2(MEM_LATENCY + 1);

    // First fetch address after reset.
    localparam logic [31:0] RESET_PC = 32'h0;

    // Instruction or data word.
    typedef logic [31:0] word_t;

    // Byte address, as held in the PC.
    typedef logic [31:0] addr_t;

    // Word index into the instruction memory.
    typedef logic [MEM_ADDR_BITS-1:0] mem_idx_t;

    // Countdown of the outstanding read.
    typedef logic [LAT_CNT_BITS-1:0] lat_cnt_t;

    // Processor request line.
    typedef enum logic {
        NOREQUEST = 1'b0,
        REQUEST   = 1'b1
    } req_e;

    // Access direction.
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } we_e;

    // Fetcher FSM.
    typedef enum logic [1:0] {
        WAIT_REQ   = 2'd0,
        WAIT_READY = 2'd1,
        WAIT_VALID = 2'd2
    } fetch_state_e;

endpackage
